//--- verilog/hud_params.svh
`ifndef HUD_PARAMS_SVH
`define HUD_PARAMS_SVH

// pixel colour, 4 bits per channel
`define COLOR_W 12

// heart row: three hearts of a 10x10 table, each cell drawn 4x4
`define HEART_CELLS     10
`define HEART_LG_SCALE  2
`define HEART_SIZE      40
`define MAX_LIVES       3

// score digit box starts at the top edge
`define DIGIT_X0        160
`define DIGIT_COLS      9
`define DIGIT_ROWS      13
`define DIGIT_LG_SCALE  1

`define DIGIT_COLOR     12'hfff
`define BAD_DIGIT_COLOR 12'hf00 // digit out of 0..9
`define BG_COLOR        12'h000

`endif

//--- verilog/pixel_pkg.sv
`default_nettype none

`include "hud_params.svh"

package pixel_pkg;

    typedef logic [`COLOR_W-1:0] color_t; // r g b, msb first
    typedef logic [10:0] screen_x_t;
    typedef logic [9:0]  screen_y_t;

endpackage

`default_nettype wire

//--- verilog/hud_pkg.sv
`default_nettype none

package hud_pkg;

    // lives left, 0 to 3
    typedef logic [1:0] lives_t;

    // one score digit, only 0 to 9 have a glyph
    typedef logic [3:0] digit_t;

endpackage

`default_nettype wire

//--- verilog/heart_sprite.sv
`timescale 1ns/1ps
`default_nettype none

`include "hud_params.svh"

module heart_sprite import pixel_pkg::*, hud_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      advance,
    input  screen_x_t x,
    input  screen_y_t y,
    input  lives_t    lives,
    output color_t    heart_color
);

    localparam int ROW_W = `HEART_CELLS * `COLOR_W;

    lives_t             heart_idx;
    logic               empty;
    logic [3:0]         col;
    logic [3:0]         row;
    logic [ROW_W-1:0]   row_bits;
    color_t             color_next;

    // one table row, leftmost cell in the top bits
    function automatic logic [ROW_W-1:0] heart_row(input logic empty_frame,
                                                   input logic [3:0] r);
        case ({empty_frame, r})
            5'b0_0000: heart_row = 120'h000_222_222_222_000_000_222_222_222_000;
            5'b0_0001: heart_row = 120'h222_733_a23_b23_222_322_a23_b23_633_222;
            5'b0_0010: heart_row = 120'h122_923_b22_b22_221_311_b22_b22_823_122;
            5'b0_0011: heart_row = 120'h122_923_b22_b22_b22_b22_b22_b22_823_122;
            5'b0_0100: heart_row = 120'h122_923_b22_b22_b22_b22_b22_b22_823_212;
            5'b0_0101: heart_row = 120'h121_823_923_b22_b22_b22_b22_933_623_211;
            5'b0_0110: heart_row = 120'h000_222_221_c12_b22_c12_c12_221_222_000;
            5'b0_0111: heart_row = 120'h000_000_000_212_b23_a23_122_000_000_000;
            5'b0_1000: heart_row = 120'h000_000_000_ccc_411_412_ccc_000_000_000;
            5'b0_1001: heart_row = 120'h000_000_000_000_211_222_000_000_000_000;
            // outline only, lost life
            5'b1_0000: heart_row = 120'h000_112_222_222_000_000_222_222_555_000;
            5'b1_0001: heart_row = 120'h222_ccc_ccc_bbb_222_222_ccc_ccc_666_222;
            5'b1_0010: heart_row = 120'h222_999_000_000_222_222_000_000_999_222;
            5'b1_0011: heart_row = 120'h222_000_000_000_000_000_000_000_999_222;
            5'b1_0100: heart_row = 120'h222_000_000_000_000_000_000_000_999_222;
            5'b1_0101: heart_row = 120'h222_000_000_000_000_000_000_000_999_222;
            5'b1_0110: heart_row = 120'h000_222_222_000_000_000_000_222_555_000;
            5'b1_0111: heart_row = 120'h000_000_000_222_000_000_222_000_000_000;
            5'b1_1000: heart_row = 120'h000_000_000_222_000_000_222_000_000_000;
            5'b1_1001: heart_row = 120'h000_000_000_000_222_222_000_000_000_000;
            default:   heart_row = '0;
        endcase
    endfunction

    assign heart_idx = lives_t'(x / `HEART_SIZE);   // valid only inside the row
    assign empty     = !(heart_idx < lives);
    assign col       = 4'((x % `HEART_SIZE) >> `HEART_LG_SCALE);
    assign row       = 4'(y >> `HEART_LG_SCALE);
    assign row_bits  = heart_row(empty, row);

    always_comb begin
        if (y >= `HEART_SIZE || x >= `MAX_LIVES * `HEART_SIZE) begin
            color_next = `BG_COLOR;
        end else begin
            color_next = row_bits[(`HEART_CELLS - 1 - col) * `COLOR_W +: `COLOR_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            heart_color <= `BG_COLOR;
        end else if (advance) begin
            heart_color <= color_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/digit_glyph.sv
`timescale 1ns/1ps
`default_nettype none

`include "hud_params.svh"

module digit_glyph import pixel_pkg::*, hud_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      advance,
    input  screen_x_t x,
    input  screen_y_t y,
    input  digit_t    digit,
    output logic      digit_on,
    output color_t    digit_color
);

    localparam int MASK_W = `DIGIT_ROWS * `DIGIT_COLS;
    localparam int BOX_W  = `DIGIT_COLS << `DIGIT_LG_SCALE;
    localparam int BOX_H  = `DIGIT_ROWS << `DIGIT_LG_SCALE;

    screen_x_t           dx;
    logic [3:0]          col;
    logic [3:0]          row;
    logic [MASK_W-1:0]   mask;
    logic [`DIGIT_COLS-1:0] row_bits;
    logic                in_box;
    color_t              color_next;

    // 13 rows of 9 bits, one octal triple per row, top row first
    function automatic logic [MASK_W-1:0] glyph_mask(input digit_t d);
        case (d)
            4'd0:    glyph_mask = 117'o174_174_307_303_303_303_303_303_303_303_303_174_174;
            4'd1:    glyph_mask = 117'o006_006_016_076_066_006_006_006_006_006_006_006_006;
            4'd2:    glyph_mask = 117'o174_174_307_303_003_014_034_020_140_340_200_377_376;
            4'd3:    glyph_mask = 117'o174_174_307_303_003_034_036_003_003_203_203_174_174;
            4'd4:    glyph_mask = 117'o004_006_036_076_066_306_706_404_777_777_004_006_006;
            4'd5:    glyph_mask = 117'o376_377_300_300_200_374_376_003_003_203_203_174_174;
            4'd6:    glyph_mask = 117'o174_174_307_303_300_334_376_343_303_303_203_174_174;
            4'd7:    glyph_mask = 117'o376_377_007_003_003_014_014_014_030_030_030_030_030;
            4'd8:    glyph_mask = 117'o174_174_307_303_203_174_376_203_303_303_203_174_174;
            4'd9:    glyph_mask = 117'o174_174_307_303_303_317_377_163_003_203_203_174_174;
            default: glyph_mask = '0;
        endcase
    endfunction

    assign dx       = x - screen_x_t'(`DIGIT_X0);
    assign in_box   = x >= `DIGIT_X0 && x < `DIGIT_X0 + BOX_W && y < BOX_H;
    assign col      = 4'(dx >> `DIGIT_LG_SCALE);
    assign row      = 4'(y >> `DIGIT_LG_SCALE);
    assign mask     = glyph_mask(digit);
    assign row_bits = mask[(`DIGIT_ROWS - 1 - row) * `DIGIT_COLS +: `DIGIT_COLS];

    always_comb begin
        if (!in_box) begin
            color_next = `BG_COLOR;
        end else if (digit > 4'd9) begin
            color_next = `BAD_DIGIT_COLOR; // whole box filled
        end else if (row_bits[`DIGIT_COLS - 1 - col]) begin
            color_next = `DIGIT_COLOR;
        end else begin
            color_next = `BG_COLOR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_on    <= 1'b0;
            digit_color <= `BG_COLOR;
        end else if (advance) begin
            digit_on    <= in_box;
            digit_color <= color_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/hud_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module hud_compositor import pixel_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   req_valid,
    output logic   req_ready,
    output logic   advance,
    input  color_t heart_color,
    input  logic   digit_on,
    input  color_t digit_color,
    output logic   pix_valid,
    input  logic   pix_ready,
    output color_t pix_color
);

    logic   s1_valid;       // lookup registers hold a request
    color_t merged_color;

    // whole pipeline moves together, stalls only on a full, blocked output
    assign advance   = !pix_valid || pix_ready;
    assign req_ready = advance;

    // lookups already resolved their regions
    assign merged_color = digit_on ? digit_color : heart_color;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            pix_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= req_valid;
            pix_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pix_color <= merged_color; // held while stalled
        end
    end

endmodule

`default_nettype wire

//--- verilog/hud_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module hud_renderer import pixel_pkg::*, hud_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  screen_x_t req_x,
    input  screen_y_t req_y,
    input  lives_t    req_lives,
    input  digit_t    req_digit,
    output logic      pix_valid,
    input  logic      pix_ready,
    output color_t    pix_color
);

    logic   advance;
    color_t heart_color;
    logic   digit_on;
    color_t digit_color;

    heart_sprite i_heart_sprite (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .x           (req_x),
        .y           (req_y),
        .lives       (req_lives),
        .heart_color (heart_color)
    );

    digit_glyph i_digit_glyph (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .x           (req_x),
        .y           (req_y),
        .digit       (req_digit),
        .digit_on    (digit_on),
        .digit_color (digit_color)
    );

    // valid tracking and final colour select
    hud_compositor i_hud_compositor (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .advance     (advance),
        .heart_color (heart_color),
        .digit_on    (digit_on),
        .digit_color (digit_color),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .pix_color   (pix_color)
    );

endmodule

`default_nettype wire

//--- test/hud_renderer_sva.sv
`timescale 1ns/1ps
`default_nettype none

module hud_renderer_sva import pixel_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   req_ready,
    input logic   pix_valid,
    input logic   pix_ready,
    input color_t pix_color
);

    int unsigned error_count = 0;

    // output register starts empty
    a_valid_after_reset: assert property (@(posedge clk) rst_n && !$past(rst_n) |-> !pix_valid)
        else begin
            $error("pix_valid high in the first cycle after reset");
            error_count++;
        end

    a_color_held: assert property (@(posedge clk) disable iff (!rst_n)
                                   pix_valid && !pix_ready |=> $stable(pix_color))
        else begin
            $error("pix_color changed while the output was stalled");
            error_count++;
        end

    // whole pipeline stall
    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
                                   req_ready == (!pix_valid || pix_ready))
        else begin
            $error("req_ready does not follow the output stall");
            error_count++;
        end

endmodule

`default_nettype wire

//--- test/hud_renderer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hud_renderer_tb import pixel_pkg::*, hud_pkg::*; ();

    localparam int          MAX_LINES  = 64;
    localparam int          FIELDS     = 5;     // x y lives digit colour
    localparam logic [15:0] EMPTY_WORD = 16'hffff;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    screen_x_t req_x;
    screen_y_t req_y;
    lives_t    req_lives;
    digit_t    req_digit;
    logic      pix_valid;
    logic      pix_ready;
    color_t    pix_color;

    logic [15:0] stim [0:MAX_LINES*FIELDS-1];
    color_t      exp_q[$];      // expected colours of accepted requests in order
    color_t      cur_expected;
    int          n_lines;
    int          n_checked;
    int          idx;
    int          cycle_count;
    int          cycle_limit;
    logic        accepted;
    logic [31:0] rnd_state;

    hud_renderer i_hud_renderer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_x     (req_x),
        .req_y     (req_y),
        .req_lives (req_lives),
        .req_digit (req_digit),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_color (pix_color)
    );

    bind hud_renderer hud_renderer_sva i_hud_renderer_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_ready (req_ready),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_color (pix_color)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_color(input string name, input color_t got, input color_t expected);
        if (got !== expected) begin
            stop_with_error($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                      $time, name, got, expected));
        end
    endtask

    task automatic load_stimulus();
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim[i] = EMPTY_WORD;
        end
        $readmemh("test/hud_input.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim[n_lines * FIELDS] != EMPTY_WORD) begin
            n_lines = n_lines + 1;
        end
        if (n_lines == 0) begin
            stop_with_error("no requests found in test/hud_input.txt");
        end
    endtask

    task automatic present_line(input int line);
        int base;
        base         = line * FIELDS;
        req_valid    = 1'b1;
        req_x        = screen_x_t'(stim[base]);
        req_y        = screen_y_t'(stim[base + 1]);
        req_lives    = lives_t'(stim[base + 2]);
        req_digit    = digit_t'(stim[base + 3]);
        cur_expected = color_t'(stim[base + 4]);
    endtask

    // scoreboard and timeout sampled on the rising edge
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_with_error("timeout, the pipeline did not deliver all pixels in time");
        end
        if (i_hud_renderer.i_hud_renderer_sva.error_count != 0) begin
            stop_with_error("a handshake assertion failed");
        end
        if (rst_n && pix_valid && pix_ready) begin
            if (exp_q.size() == 0) begin
                stop_with_error("a pixel came out with no accepted request behind it");
            end else begin
                check_color("pix_color", pix_color, exp_q.pop_front());
                n_checked = n_checked + 1;
            end
        end
        if (rst_n && req_valid && req_ready) begin
            exp_q.push_back(cur_expected);
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_x        = '0;
        req_y        = '0;
        req_lives    = '0;
        req_digit    = '0;
        pix_ready    = 1'b0;
        cur_expected = '0;
        n_checked    = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        accepted     = 1'b0;
        rnd_state    = 32'h5c65_fb65;

        load_stimulus();
        cycle_limit = 40 * n_lines + 100;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idx = 0;
        while (n_checked < n_lines) begin
            rnd_state = next_random(rnd_state);
            pix_ready = (rnd_state[30:29] != 2'd0);    // back-pressure about a quarter of the time
            if (req_valid && !accepted) begin
                // hold the request until it is taken
            end else if (idx < n_lines && rnd_state[25:24] != 2'd0) begin
                present_line(idx);
                idx = idx + 1;
            end else begin
                req_valid = 1'b0;       // idle gap
            end
            @(posedge clk);
            accepted = req_valid && req_ready;
            #1;
        end

        // drain with the output open so any extra pixel shows up
        req_valid = 1'b0;
        pix_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;

        if (i_hud_renderer.i_hud_renderer_sva.error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_with_error("a handshake assertion failed near the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- test/hud_input.txt
// columns, all hex: x  y  lives  digit  expected colour (12-bit rgb)
// full hearts, index below lives
004 004 3 0 733
008 00c 1 0 b22
00b 00f 1 0 b22
009 00d 1 0 b22
032 014 2 0 923
064 020 3 0 412
// empty hearts, index at or above lives
05c 020 2 0 222
004 004 0 0 ccc
02c 008 0 0 999
070 010 0 0 999
020 000 0 0 555
048 000 1 0 555
// digit box, glyph mask
0a0 000 3 0 000
0a4 001 3 0 fff
0ae 006 3 1 fff
0b1 006 3 1 000
0a2 005 3 8 fff
0a8 005 3 8 000
0a1 019 3 7 000
0a8 019 3 7 fff
// digit values above 9 fill the box
0a0 000 3 a f00
0b1 019 3 f f00
0aa 00d 3 c f00
// outside both regions
0b2 000 3 f 000
0aa 01a 3 c 000
082 005 3 5 000
00a 028 3 5 000
078 000 3 0 000
7ff 3ff 3 9 000

//--- list.f
+incdir+verilog
verilog/pixel_pkg.sv
verilog/hud_pkg.sv
verilog/heart_sprite.sv
verilog/digit_glyph.sv
verilog/hud_compositor.sv
verilog/hud_renderer.sv
test/hud_renderer_sva.sv
test/hud_renderer_tb.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass message
rm -f sim.log
verilator --binary --timing --top-module hud_renderer_tb -f list.f -o hud_sim \
    && ./obj_dir/hud_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
